/* all.f */
src/memRrPkg.sv
src/physRegFile.sv
src/regReadArbiter.sv
src/memRegReadStage.sv
src/memRegReadTop.sv
sim/memRegReadTb_assert.sv
sim/memRegReadTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory register read testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module memRegReadTb \
    -f all.f \
    -o memRegReadSim

# Keep running after an assertion error so the testbench prints its verdict
output=$(./obj_dir/memRegReadSim +verilator+error+limit+1000 | tee /dev/stderr)

if grep -q "TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1

/* sim/memRegReadTb.sv */
// ####################
// Testbench for the memory register read subsystem
// Stimulus, register file model, scoreboard, watchdog
// ####################

`timescale 1ns/1ns

module memRegReadTb;

    localparam int numLanes      = memRrPkg::numMemLanes;
    localparam int numRegs       = 64;
    localparam int opsPerLane    = 60;
    localparam int clkPeriod     = 8;
    localparam int timeoutCycles = numLanes * opsPerLane * 40;

    logic                  clk;
    logic                  rst;
    logic [numLanes-1:0]   issueValid;
    logic [numLanes-1:0]   issueReady;
    memRrPkg::MemIssueOp   issueOp [numLanes];
    logic [numLanes-1:0]   execValid;
    logic [numLanes-1:0]   execReady;
    memRrPkg::MemExecOp    execOp [numLanes];
    memRrPkg::FlushRange   flush;
    logic                  wbValid;
    memRrPkg::PhysRegNum   wbReg;
    memRrPkg::DataWord     wbData;
    logic                  allocValid;
    memRrPkg::PhysRegNum   allocReg;

    // Reference model state
    memRrPkg::DataWord     modelData [numRegs];
    logic                  modelReady [numRegs];
    memRrPkg::MemIssueOp   pendingQ [numLanes][$];
    memRrPkg::MemExecOp    expectQ [numLanes][$];
    int                    errCount = 0;
    int                    checkedCount = 0;
    int                    sentCount [numLanes];
    logic [numLanes-1:0]   accepted;

    memRegReadTop #(
        .numPhysRegs (numRegs)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issueReady (issueReady),
        .issueOp    (issueOp),
        .execValid  (execValid),
        .execReady  (execReady),
        .execOp     (execOp),
        .flush      (flush),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .allocValid (allocValid),
        .allocReg   (allocReg)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Distance from head compared with the range length, modulo the list size
    function automatic bit ptrFlushed(memRrPkg::FlushRange f, memRrPkg::ActiveListPtr p);
        memRrPkg::ActiveListPtr offset;
        memRrPkg::ActiveListPtr span;
        offset = p - f.head;
        span   = f.tail - f.head;
        return f.active && (f.all || offset < span);
    endfunction

    function automatic memRrPkg::Operand expectOperand(memRrPkg::OperandType t,
                                                       memRrPkg::PhysRegNum r,
                                                       memRrPkg::Addr pc);
        memRrPkg::Operand o;
        o.valid = 1'b1;
        o.data  = '0;
        if (t == memRrPkg::OPND_REG) begin
            o.data  = modelData[r];
            o.valid = modelReady[r];
        end else if (t == memRrPkg::OPND_PC) begin
            o.data = pc;
        end
        return o;
    endfunction

    function automatic memRrPkg::MemIssueOp randomOp(memRrPkg::OpId id);
        memRrPkg::MemIssueOp op;
        op.opId          = id;
        op.pc            = $urandom;
        op.activeListPtr = memRrPkg::ActiveListPtr'($urandom);
        // Small register set so reads meet allocate and writeback traffic
        op.srcRegA       = memRrPkg::PhysRegNum'($urandom % 8);
        op.srcRegB       = memRrPkg::PhysRegNum'($urandom % 8);
        op.operandTypeA  = memRrPkg::OperandType'($urandom % 3);
        op.operandTypeB  = memRrPkg::OperandType'($urandom % 3);
        op.dstReg        = memRrPkg::PhysRegNum'($urandom);
        op.writeReg      = 1'($urandom % 2);
        op.isStore       = 1'($urandom % 2);
        return op;
    endfunction

    task automatic checkExec(int lane, memRrPkg::MemExecOp exp, memRrPkg::MemExecOp act);
        checkedCount++;
        assert (act.op == exp.op) else begin
            errCount++;
            $display("FAIL integrity lane %0d: expected %h actual %h", lane, exp.op, act.op);
        end
        assert (act.operandA == exp.operandA) else begin
            errCount++;
            $display("FAIL operandA lane %0d: expected %h actual %h",
                     lane, exp.operandA, act.operandA);
        end
        assert (act.operandB == exp.operandB) else begin
            errCount++;
            $display("FAIL operandB lane %0d: expected %h actual %h",
                     lane, exp.operandB, act.operandB);
        end
    endtask

    // Scoreboard on the values present just before each edge
    always @(posedge clk) begin : scoreboard
        memRrPkg::MemIssueOp slotOp;
        memRrPkg::MemExecOp  expOp;
        logic                expReady;
        if (rst) begin
            for (int r = 0; r < numRegs; r++) begin
                modelData[r]  = '0;
                modelReady[r] = 1'b1;
            end
            for (int l = 0; l < numLanes; l++) begin
                pendingQ[l].delete();
                expectQ[l].delete();
            end
        end else begin
            for (int l = 0; l < numLanes; l++) begin
                // Read slot is free when no accepted op waits for its grant
                expReady = (pendingQ[l].size() == 0) && !flush.active;
                assert (issueReady[l] == expReady) else begin
                    errCount++;
                    $display("FAIL issueReady lane %0d: expected %b actual %b",
                             l, expReady, issueReady[l]);
                end
                if (execValid[l] && execReady[l]) begin
                    if (expectQ[l].size() == 0) begin
                        errCount++;
                        $display("Lane %0d delivered an op that was never expected", l);
                    end else begin
                        checkExec(l, expectQ[l].pop_front(), execOp[l]);
                    end
                end
                if (flush.active) begin
                    for (int k = pendingQ[l].size() - 1; k >= 0; k--) begin
                        if (ptrFlushed(flush, pendingQ[l][k].activeListPtr)) begin
                            pendingQ[l].delete(k);
                        end
                    end
                    for (int k = expectQ[l].size() - 1; k >= 0; k--) begin
                        if (ptrFlushed(flush, expectQ[l][k].op.activeListPtr)) begin
                            expectQ[l].delete(k);
                        end
                    end
                end
                // Operands are snapshotted at the grant, before this edge's writes
                if (UUT.rdGrant[l]) begin
                    if (pendingQ[l].size() == 0) begin
                        errCount++;
                        $display("Lane %0d was granted the read port with no op waiting", l);
                    end else begin
                        slotOp         = pendingQ[l].pop_front();
                        expOp.op       = slotOp;
                        expOp.operandA = expectOperand(slotOp.operandTypeA,
                                                       slotOp.srcRegA, slotOp.pc);
                        expOp.operandB = expectOperand(slotOp.operandTypeB,
                                                       slotOp.srcRegB, slotOp.pc);
                        expectQ[l].push_back(expOp);
                    end
                end
                if (issueValid[l] && issueReady[l]) begin
                    pendingQ[l].push_back(issueOp[l]);
                end
            end
            if (allocValid) begin
                modelReady[allocReg] = 1'b0;
            end
            if (wbValid) begin
                modelData[wbReg]  = wbData;
                modelReady[wbReg] = 1'b1;
            end
        end
    end

    function automatic bit allDone();
        bit done;
        done = 1'b1;
        for (int l = 0; l < numLanes; l++) begin
            if (sentCount[l] < opsPerLane || pendingQ[l].size() != 0 ||
                expectQ[l].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    initial begin : stimulus
        void'($urandom(32'hb262_9a61));
        rst        = 1'b1;
        issueValid = '0;
        execReady  = '0;
        flush      = '0;
        wbValid    = 1'b0;
        wbReg      = '0;
        wbData     = '0;
        allocValid = 1'b0;
        allocReg   = '0;
        for (int l = 0; l < numLanes; l++) begin
            issueOp[l]   = '0;
            sentCount[l] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!allDone()) begin
            @(posedge clk);
            for (int l = 0; l < numLanes; l++) begin
                accepted[l] = issueValid[l] && issueReady[l];
            end
            #1;
            for (int l = 0; l < numLanes; l++) begin
                if (accepted[l]) begin
                    sentCount[l]++;
                end
                // An op stays on the bus until it is taken
                if (!issueValid[l] || accepted[l]) begin
                    if (sentCount[l] < opsPerLane && $urandom % 5 != 0) begin
                        issueOp[l]    = randomOp(memRrPkg::OpId'(l * 128 + sentCount[l]));
                        issueValid[l] = 1'b1;
                    end else begin
                        issueValid[l] = 1'b0;
                    end
                end
                execReady[l] = ($urandom % 10 < 7);
            end
            flush.active = ($urandom % 16 == 0);
            flush.all    = ($urandom % 4 == 0);
            flush.head   = memRrPkg::ActiveListPtr'($urandom);
            flush.tail   = memRrPkg::ActiveListPtr'($urandom);
            wbValid      = ($urandom % 3 == 0);
            wbReg        = memRrPkg::PhysRegNum'($urandom % 8);
            wbData       = $urandom;
            allocValid   = ($urandom % 4 == 0);
            allocReg     = memRrPkg::PhysRegNum'($urandom % 8);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d scoreboard, %0d protocol; ops checked %0d",
                 errCount, UUT.propChecks.failCount, checkedCount);
        if (errCount == 0 && UUT.propChecks.failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeoutCycles * clkPeriod);
        $display("Watchdog expired before every op left the pipeline");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sim/memRegReadTb_assert.sv */
// ####################
// Concurrent checks on the read port arbiter
// and the execution handshake
// ####################

`timescale 1ns/1ns

module protocolChecks (
    input logic                               clk,
    input logic                               rst,
    input logic [memRrPkg::numMemLanes-1:0]   rdReq,
    input logic [memRrPkg::numMemLanes-1:0]   rdGrant,
    input logic [memRrPkg::numMemLanes-1:0]   execValid,
    input logic [memRrPkg::numMemLanes-1:0]   execReady,
    input memRrPkg::MemExecOp                 execOp [memRrPkg::numMemLanes]
);

    int failCount = 0;

    // At most one lane owns the read port
    grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(rdGrant))
        else begin
            failCount++;
            $error("read port grant is not one-hot");
        end

    grantToRequester: assert property (@(posedge clk) disable iff (rst)
        (rdGrant & ~rdReq) == '0)
        else begin
            failCount++;
            $error("read port granted to a lane that did not request it");
        end

    for (genvar i = 0; i < memRrPkg::numMemLanes; i++) begin : gLane
        // Refused once, then served on the next request
        grantBound: assert property (@(posedge clk) disable iff (rst)
            (rdReq[i] && !rdGrant[i]) |=> (!rdReq[i] || rdGrant[i]))
            else begin
                failCount++;
                $error("lane %0d kept requesting without a grant", i);
            end

        // Stalled output op must not change
        execHold: assert property (@(posedge clk) disable iff (rst)
            (execValid[i] && !execReady[i]) |=> $stable(execOp[i]))
            else begin
                failCount++;
                $error("lane %0d changed its output op while stalled", i);
            end
    end

endmodule

bind memRegReadTop protocolChecks propChecks (
    .clk       (clk),
    .rst       (rst),
    .rdReq     (rdReq),
    .rdGrant   (rdGrant),
    .execValid (execValid),
    .execReady (execReady),
    .execOp    (execOp)
);

/* src/memRegReadStage.sv */
// ####################
// Register read stage for one memory lane
// Read slot, operand select, selective flush,
// output register toward execution
// ####################

`timescale 1ns/1ns

module memRegReadStage (
    input  logic                  clk,
    input  logic                  rst,

    // Issue side
    input  logic                  issueValid,
    output logic                  issueReady,
    input  memRrPkg::MemIssueOp   issueOp,

    // Execution side
    output logic                  execValid,
    input  logic                  execReady,
    output memRrPkg::MemExecOp    execOp,

    input  memRrPkg::FlushRange   flush,

    // Shared read port
    output logic                  rdReq,
    output memRrPkg::RegReadReq   rdAddr,
    input  logic                  rdGrant,
    input  memRrPkg::RegReadResp  rdResp
);

    // Picks register data, pc or zero for one source
    function automatic memRrPkg::Operand selectOperand(
        memRrPkg::OperandType opndType,
        memRrPkg::DataWord    regData,
        logic                 regReady,
        memRrPkg::Addr        pc
    );
        memRrPkg::Operand result;
        case (opndType)
            memRrPkg::OPND_REG: begin
                result.data  = regData;
                result.valid = regReady;
            end
            memRrPkg::OPND_PC: begin
                result.data  = pc;
                result.valid = 1'b1;
            end
            default: begin
                result.data  = '0;
                result.valid = 1'b1;
            end
        endcase
        return result;
    endfunction

    // Read slot
    logic                slotValid;
    memRrPkg::MemIssueOp slotOp;

    // Output register
    logic                outValid;
    memRrPkg::MemExecOp  outOp;

    logic               flushSlot;
    logic               flushOut;
    logic               acceptIssue;
    logic               execFire;
    logic               outFree;
    logic               readDone;
    memRrPkg::MemExecOp nextExecOp;

    assign flushSlot = slotValid && memRrPkg::inFlushRange(flush, slotOp.activeListPtr);
    assign flushOut  = outValid && memRrPkg::inFlushRange(flush, outOp.op.activeListPtr);

    // No new op while a flush is in progress
    assign issueReady  = !slotValid && !flush.active;
    assign acceptIssue = issueValid && issueReady;

    // A flushed op is never offered downstream
    assign execValid = outValid && !flushOut;
    assign execOp    = outOp;
    assign execFire  = execValid && execReady;

    // Output register is empty or emptying this cycle
    assign outFree = !outValid || flushOut || execReady;

    assign rdReq       = slotValid && !flushSlot && outFree;
    assign rdAddr.regA = slotOp.srcRegA;
    assign rdAddr.regB = slotOp.srcRegB;
    assign readDone    = rdReq && rdGrant;

    // Operands come straight from the read response
    always_comb begin
        nextExecOp.op       = slotOp;
        nextExecOp.operandA = selectOperand(
            slotOp.operandTypeA, rdResp.dataA, rdResp.readyA, slotOp.pc
        );
        nextExecOp.operandB = selectOperand(
            slotOp.operandTypeB, rdResp.dataB, rdResp.readyB, slotOp.pc
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
            outValid  <= 1'b0;
        end else begin
            // Slot fills on issue, drains on grant or flush
            if (acceptIssue) begin
                slotValid <= 1'b1;
            end else if (readDone || flushSlot) begin
                slotValid <= 1'b0;
            end

            if (readDone) begin
                outValid <= 1'b1;
            end else if (execFire || flushOut) begin
                outValid <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (acceptIssue) begin
            slotOp <= issueOp;
        end
        if (readDone) begin
            outOp <= nextExecOp;
        end
    end

endmodule

/* src/memRegReadTop.sv */
// ####################
// Memory register read subsystem
// Two lane stages, read port arbiter, register file
// ####################

`timescale 1ns/1ns

module memRegReadTop #(
    parameter int numPhysRegs = 64
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [memRrPkg::numMemLanes-1:0]          issueValid,
    output logic [memRrPkg::numMemLanes-1:0]          issueReady,
    input  memRrPkg::MemIssueOp                       issueOp [memRrPkg::numMemLanes],
    output logic [memRrPkg::numMemLanes-1:0]          execValid,
    input  logic [memRrPkg::numMemLanes-1:0]          execReady,
    output memRrPkg::MemExecOp                        execOp [memRrPkg::numMemLanes],
    input  memRrPkg::FlushRange                       flush,
    input  logic                                      wbValid,
    input  memRrPkg::PhysRegNum                       wbReg,
    input  memRrPkg::DataWord                         wbData,
    input  logic                                      allocValid,
    input  memRrPkg::PhysRegNum                       allocReg
);

    logic [memRrPkg::numMemLanes-1:0] rdReq;
    logic [memRrPkg::numMemLanes-1:0] rdGrant;
    memRrPkg::RegReadReq              rdAddr [memRrPkg::numMemLanes];
    memRrPkg::RegReadReq              portAddr;
    memRrPkg::RegReadResp             rdResp;

    for (genvar i = 0; i < memRrPkg::numMemLanes; i++) begin : gLane
        memRegReadStage stage (
            .clk        (clk),
            .rst        (rst),
            .issueValid (issueValid[i]),
            .issueReady (issueReady[i]),
            .issueOp    (issueOp[i]),
            .execValid  (execValid[i]),
            .execReady  (execReady[i]),
            .execOp     (execOp[i]),
            .flush      (flush),
            .rdReq      (rdReq[i]),
            .rdAddr     (rdAddr[i]),
            .rdGrant    (rdGrant[i]),
            .rdResp     (rdResp)
        );
    end

    regReadArbiter #(
        .numReq (memRrPkg::numMemLanes)
    ) arbiter (
        .clk   (clk),
        .rst   (rst),
        .req   (rdReq),
        .grant (rdGrant)
    );

    // Granted lane drives the read address
    always_comb begin
        portAddr = '0;
        for (int i = 0; i < memRrPkg::numMemLanes; i++) begin
            if (rdGrant[i]) begin
                portAddr = rdAddr[i];
            end
        end
    end

    physRegFile #(
        .numPhysRegs (numPhysRegs)
    ) regFile (
        .clk        (clk),
        .rst        (rst),
        .rdAddr     (portAddr),
        .rdResp     (rdResp),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .allocValid (allocValid),
        .allocReg   (allocReg)
    );

endmodule

/* src/memRrPkg.sv */
// ####################
// Shared widths, operand type enum, pipeline structs
// and the selective flush range check
// ####################

package memRrPkg;

    // Number of memory issue lanes sharing the read port
    localparam int numMemLanes = 2;

    typedef logic [31:0] DataWord;
    typedef logic [5:0]  PhysRegNum;
    typedef logic [4:0]  ActiveListPtr;
    typedef logic [7:0]  OpId;
    typedef logic [31:0] Addr;

    // Source operand kinds for memory micro-ops
    typedef enum logic [1:0] {
        OPND_REG  = 2'd0,
        OPND_PC   = 2'd1,
        OPND_ZERO = 2'd2
    } OperandType;

    // Issued load or store micro-op
    typedef struct packed {
        OpId          opId;
        Addr          pc;
        ActiveListPtr activeListPtr;
        PhysRegNum    srcRegA;
        PhysRegNum    srcRegB;
        OperandType   operandTypeA;
        OperandType   operandTypeB;
        PhysRegNum    dstReg;
        logic         writeReg;
        logic         isStore;
    } MemIssueOp;

    typedef struct packed {
        DataWord data;
        logic    valid;
    } Operand;

    // Micro-op with resolved operands, sent to execution
    typedef struct packed {
        MemIssueOp op;
        Operand    operandA;
        Operand    operandB;
    } MemExecOp;

    typedef struct packed {
        PhysRegNum regA;
        PhysRegNum regB;
    } RegReadReq;

    typedef struct packed {
        DataWord dataA;
        logic    readyA;
        DataWord dataB;
        logic    readyB;
    } RegReadResp;

    // Range is head inclusive to tail exclusive, may wrap
    typedef struct packed {
        logic         active;
        logic         all;
        ActiveListPtr head;
        ActiveListPtr tail;
    } FlushRange;

    function automatic logic inFlushRange(FlushRange range, ActiveListPtr ptr);
        logic hit;
        if (!range.active) begin
            hit = 1'b0;
        end else if (range.all) begin
            hit = 1'b1;
        end else if (range.head <= range.tail) begin
            hit = (ptr >= range.head) && (ptr < range.tail);
        end else begin
            // Wrapped range
            hit = (ptr >= range.head) || (ptr < range.tail);
        end
        return hit;
    endfunction

endpackage

/* src/physRegFile.sv */
// ####################
// Physical register file with ready bits,
// one dual-operand read port, writeback and allocate
// ####################

`timescale 1ns/1ns

module physRegFile #(
    parameter int numPhysRegs = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  memRrPkg::RegReadReq   rdAddr,
    output memRrPkg::RegReadResp  rdResp,
    input  logic                  wbValid,
    input  memRrPkg::PhysRegNum   wbReg,
    input  memRrPkg::DataWord     wbData,
    input  logic                  allocValid,
    input  memRrPkg::PhysRegNum   allocReg
);

    memRrPkg::DataWord        regData [numPhysRegs];
    logic [numPhysRegs-1:0]   regReady;

    logic wbInRange;
    logic allocInRange;
    logic aInRange;
    logic bInRange;

    // Register numbers beyond the array are ignored
    assign wbInRange    = int'(wbReg) < numPhysRegs;
    assign allocInRange = int'(allocReg) < numPhysRegs;
    assign aInRange     = int'(rdAddr.regA) < numPhysRegs;
    assign bInRange     = int'(rdAddr.regB) < numPhysRegs;

    // Combinational read, sees the value before this cycle's write
    always_comb begin
        rdResp.dataA  = aInRange ? regData[rdAddr.regA] : '0;
        rdResp.readyA = aInRange ? regReady[rdAddr.regA] : 1'b0;
        rdResp.dataB  = bInRange ? regData[rdAddr.regB] : '0;
        rdResp.readyB = bInRange ? regReady[rdAddr.regB] : 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numPhysRegs; i++) begin
                regData[i] <= '0;
            end
            regReady <= '1;
        end else begin
            if (allocValid && allocInRange) begin
                regReady[allocReg] <= 1'b0;
            end
            // Writeback comes second so it wins over allocate
            if (wbValid && wbInRange) begin
                regData[wbReg]  <= wbData;
                regReady[wbReg] <= 1'b1;
            end
        end
    end

endmodule

/* src/regReadArbiter.sv */
// ####################
// Round-robin arbiter for the shared read port
// ####################

`timescale 1ns/1ns

module regReadArbiter #(
    parameter int numReq = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [numReq-1:0] req,
    output logic [numReq-1:0] grant
);

    localparam int ptrWidth = (numReq > 1) ? $clog2(numReq) : 1;

    logic [ptrWidth-1:0] prioPtr;
    logic [ptrWidth-1:0] grantIdx;
    logic                granted;

    // Search starts at the priority pointer and wraps
    always_comb begin
        int idx;
        grant    = '0;
        grantIdx = prioPtr;
        granted  = 1'b0;
        for (int k = 0; k < numReq; k++) begin
            idx = (int'(prioPtr) + k) % numReq;
            if (!granted && req[idx]) begin
                grant[idx] = 1'b1;
                grantIdx   = ptrWidth'(idx);
                granted    = 1'b1;
            end
        end
    end

    // Pointer only moves past a lane that was granted
    always_ff @(posedge clk) begin
        if (rst) begin
            prioPtr <= '0;
        end else if (granted) begin
            if (int'(grantIdx) == numReq - 1) begin
                prioPtr <= '0;
            end else begin
                prioPtr <= grantIdx + 1'b1;
            end
        end
    end

endmodule
